//--- logic/map_205_pkg.sv
package map_205_pkg;

	// bus and storage widths
	typedef logic [7:0]  byte_t;     // cpu data, register contents and save-state data
	typedef logic [14:0] cpu_addr_t; // cpu address below A15
	typedef logic [13:0] ppu_addr_t;
	typedef logic [18:0] rom_addr_t; // prg and chr rom, 512 KB each
	typedef logic [1:0]  block_t;    // outer 128 KB block of the multicart
	typedef logic [7:0]  ss_addr_t;

	// mmc3 control register indices, formed from cpu A14, A13 and A0
	// index 1 is bank data, indices 5 to 7 are the irq reload, disable and enable strobes
	localparam logic [2:0] REG_CFG     = 3'd0; // bank select, prg swap and chr invert
	localparam logic [2:0] REG_MIRROR  = 3'd2;
	localparam logic [2:0] REG_RAM_CFG = 3'd3;
	localparam logic [2:0] REG_RELOAD  = 3'd4; // irq reload value

	// save-state map
	// addresses 0 to 7 hold the control registers and 8 to 15 the bank registers
	localparam ss_addr_t SS_IRQ_CTR = 8'd16;
	localparam ss_addr_t SS_STATUS  = 8'd17; // irq flags and block
	localparam ss_addr_t SS_MAP_IDX = 8'd127;

endpackage

//--- logic/mmc3_regs.sv
`timescale 1ns/100ps

module mmc3_regs
	import map_205_pkg::*;
#(
	parameter byte_t MAP_IDX = 8'd205
)
(
	input  logic      m2,
	input  logic      map_rst,
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_dat,
	input  logic      cpu_ce,
	input  logic      cpu_rw,
	input  logic      cfg_mir_v,
	input  logic      ss_act,
	input  logic      ss_we,
	input  ss_addr_t  ss_addr,
	input  byte_t     irq_ctr,
	input  byte_t     irq_status_byte,
	output byte_t     bank_regs [0:7],
	output logic      swap_control,
	output logic      chr_invert,
	output logic      mirror_mode,
	output logic      ram_on,
	output block_t    block,
	output byte_t     reload_val,
	output logic      irq_reload_wr,
	output logic      irq_disable_wr,
	output logic      irq_enable_wr,
	output logic      ss_irq_we,
	output byte_t     ss_irq_dat,
	output byte_t     ss_rdat
);

	byte_t      mmc_regs [0:7];
	logic [2:0] reg_idx;
	logic       reg_wr;
	logic       blk_wr;
	logic       ss_wr;

	assign reg_idx = {cpu_addr[14], cpu_addr[13], cpu_addr[0]};

	// cpu writes are held off while a save-state transfer runs
	assign reg_wr = !ss_act & !cpu_ce & !cpu_rw;
	assign blk_wr = !ss_act & cpu_ce & !cpu_rw & (cpu_addr[14:13] == 2'b11); // $6000-$7FFF
	assign ss_wr  = ss_act & ss_we;

	assign swap_control = mmc_regs[REG_CFG][6];
	assign chr_invert   = mmc_regs[REG_CFG][7];
	assign mirror_mode  = mmc_regs[REG_MIRROR][0]; // 1 selects horizontal
	assign ram_on       = mmc_regs[REG_RAM_CFG][7];
	assign reload_val   = mmc_regs[REG_RELOAD];

	assign irq_reload_wr  = reg_wr & (reg_idx == 3'd5);
	assign irq_disable_wr = reg_wr & (reg_idx == 3'd6);
	assign irq_enable_wr  = reg_wr & (reg_idx == 3'd7);

	// the save-state port carries its write data on the cpu data bus
	assign ss_irq_we  = ss_wr & (ss_addr == SS_STATUS);
	assign ss_irq_dat = cpu_dat;

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			for (int i = 0; i < 8; i++)
				mmc_regs[i] <= '0;
			mmc_regs[REG_MIRROR] <= {7'd0, cfg_mir_v};

			// power-on banks, chr 0/2 in 2 KB and 4-7 in 1 KB, prg 0 and 1
			bank_regs[0] <= 8'd0;
			bank_regs[1] <= 8'd2;
			bank_regs[2] <= 8'd4;
			bank_regs[3] <= 8'd5;
			bank_regs[4] <= 8'd6;
			bank_regs[5] <= 8'd7;
			bank_regs[6] <= 8'd0;
			bank_regs[7] <= 8'd1;

			block <= '0;
		end
		else if (ss_wr)
		begin
			if (ss_addr[7:3] == 5'd0)
				mmc_regs[ss_addr[2:0]] <= cpu_dat;
			else if (ss_addr[7:3] == 5'd1)
				bank_regs[ss_addr[2:0]] <= cpu_dat;
			else if (ss_addr == SS_STATUS)
				block <= cpu_dat[6:5]; // irq flags of this byte go to the irq block
		end
		else if (reg_wr)
		begin
			mmc_regs[reg_idx] <= cpu_dat;
			if (reg_idx == 3'd1)
				bank_regs[mmc_regs[REG_CFG][2:0]] <= cpu_dat;
		end
		else if (blk_wr)
			block <= cpu_dat[1:0];
	end

	always_comb
	begin
		if (ss_addr[7:3] == 5'd0)
			ss_rdat = mmc_regs[ss_addr[2:0]];
		else if (ss_addr[7:3] == 5'd1)
			ss_rdat = bank_regs[ss_addr[2:0]];
		else if (ss_addr == SS_IRQ_CTR)
			ss_rdat = irq_ctr;
		else if (ss_addr == SS_STATUS)
			ss_rdat = irq_status_byte | {1'b0, block, 5'd0};
		else if (ss_addr == SS_MAP_IDX)
			ss_rdat = MAP_IDX;
		else
			ss_rdat = 8'hff;
	end

endmodule

//--- logic/prg_bank_map.sv
`timescale 1ns/100ps

module prg_bank_map
	import map_205_pkg::*;
(
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_ce,
	input  byte_t     bank_regs [0:7],
	input  logic      swap_control,
	input  block_t    block,
	output rom_addr_t prg_addr
);

	logic [4:0] prg_bank; // 8 KB bank within the 32-bank window of a block
	logic [5:0] prg_outer;

	always_comb
	begin
		if (cpu_ce)
			prg_bank = '0;
		else
		begin
			case (cpu_addr[14:13])
				2'd0:
					prg_bank = swap_control ? 5'h1e : bank_regs[6][4:0];
				2'd1:
					prg_bank = bank_regs[7][4:0];
				2'd2:
					prg_bank = swap_control ? bank_regs[6][4:0] : 5'h1e;
				default:
					prg_bank = 5'h1f; // $E000 is fixed to the last bank
			endcase
		end
	end

	// blocks 0 and 1 span 256 KB each and blocks 2 and 3 span 128 KB each
	always_comb
	begin
		if (!block[1])
			prg_outer = {block[0], prg_bank};
		else
			prg_outer = {block, prg_bank[3:0]};
	end

	assign prg_addr = {prg_outer, cpu_addr[12:0]};

endmodule

//--- logic/chr_bank_map.sv
`timescale 1ns/100ps

module chr_bank_map
	import map_205_pkg::*;
(
	input  ppu_addr_t ppu_addr,
	input  logic      ppu_we,
	input  logic      cfg_chr_ram,
	input  byte_t     bank_regs [0:7],
	input  logic      chr_invert,
	input  logic      mirror_mode,
	input  block_t    block,
	output rom_addr_t chr_addr,
	output logic      chr_ce,
	output logic      chr_we,
	output logic      ciram_a10,
	output logic      ciram_ce
);

	byte_t      chr_bank; // 1 KB bank number
	logic [8:0] chr_outer;
	logic       pattern_area;

	// chr_invert swaps which pattern table half gets the 2 KB banks
	always_comb
	begin
		if (ppu_addr[12] == chr_invert)
			chr_bank = {bank_regs[{2'b00, ppu_addr[11]}][7:1], ppu_addr[10]};
		else
			chr_bank = bank_regs[3'd2 + {1'b0, ppu_addr[11:10]}];
	end

	always_comb
	begin
		if (block == 2'd0)
			chr_outer = {1'b0, chr_bank}; // block 0 sees the first 256 KB
		else
			chr_outer = {block, chr_bank[6:0]};
	end

	assign chr_addr = {chr_outer, ppu_addr[9:0]};

	assign pattern_area = !ppu_addr[13];
	assign chr_ce       = pattern_area;
	assign ciram_ce     = pattern_area; // active low, so ciram is enabled above $2000

	// ppu_we is active low
	assign chr_we = cfg_chr_ram & !ppu_we & pattern_area;

	// vertical mirroring follows A10, horizontal follows A11
	assign ciram_a10 = mirror_mode ? ppu_addr[11] : ppu_addr[10];

endmodule

//--- logic/scanline_irq.sv
`timescale 1ns/100ps

module scanline_irq
	import map_205_pkg::*;
#(
	parameter int A12_QUIET = 4
)
(
	input  logic  m2,
	input  logic  map_rst,
	input  logic  ss_act,
	input  logic  ppu_addr12,
	input  logic  mmc3b_mode,
	input  byte_t reload_val,
	input  logic  irq_reload_wr,
	input  logic  irq_disable_wr,
	input  logic  irq_enable_wr,
	input  logic  ss_irq_we,
	input  byte_t ss_irq_dat,
	output logic  irq,
	output byte_t irq_ctr,
	output byte_t irq_status_byte
);

	logic [A12_QUIET-1:0] a12_hist; // newest sample in bit 0
	logic                 a12_rise;
	logic                 irq_on;
	logic                 irq_pend;
	logic                 irq_reload_req;
	logic                 ctr_reload;
	logic                 irq_act;

	// a rise only counts after A12 has been low long enough, which drops the
	// short A12 pulses of sprite fetches within one scanline
	assign a12_rise = !ss_act & ppu_addr12 & (a12_hist == '0);

	// the MMC3B reloads on every clock that finds the counter at 0
	assign ctr_reload = irq_reload_req | (mmc3b_mode & (irq_ctr == 8'd0));

	assign irq_act = irq_on & a12_rise &
		((!ctr_reload & (irq_ctr == 8'd1)) | (ctr_reload & (reload_val == 8'd0)));

	assign irq = irq_pend | irq_act;

	// save-state keeps each flag as a bit pair and any mismatch means set
	assign irq_status_byte = {3'b000, irq_on, irq_pend, 1'b0, irq_reload_req, 1'b0};

	always_ff @(negedge m2)
	begin
		if (!ss_act)
			a12_hist <= {a12_hist[A12_QUIET-2:0], ppu_addr12};
	end

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			irq_on         <= 1'b0;
			irq_pend       <= 1'b0;
			irq_reload_req <= 1'b0;
			irq_ctr        <= '0;
		end
		else if (ss_act)
		begin
			if (ss_irq_we)
			begin
				irq_reload_req <= ss_irq_dat[1] ^ ss_irq_dat[0];
				irq_pend       <= ss_irq_dat[3] ^ ss_irq_dat[2];
				irq_on         <= ss_irq_dat[4];
			end
		end
		else
		begin
			if (a12_rise)
			begin
				if (ctr_reload)
				begin
					irq_ctr        <= reload_val;
					irq_reload_req <= 1'b0;
				end
				else if (irq_ctr == 8'd0)
					irq_ctr <= reload_val;
				else
					irq_ctr <= irq_ctr - 8'd1;

				if (irq_act)
					irq_pend <= 1'b1;
			end

			// register writes win over a counter clock in the same cycle
			if (irq_reload_wr)
				irq_reload_req <= 1'b1;
			if (irq_disable_wr)
			begin
				irq_on   <= 1'b0;
				irq_pend <= 1'b0; // disabling also acknowledges
			end
			if (irq_enable_wr)
				irq_on <= 1'b1;
		end
	end

endmodule

//--- logic/map_205.sv
`timescale 1ns/100ps

module map_205
	import map_205_pkg::*;
#(
	parameter byte_t MAP_IDX   = 8'd205,
	parameter int    A12_QUIET = 4
)
(
	input  logic      m2,
	input  logic      map_rst,
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_dat,
	input  logic      cpu_ce,
	input  logic      cpu_rw,
	input  ppu_addr_t ppu_addr,
	input  logic      ppu_oe,
	input  logic      ppu_we,
	input  logic      cfg_mir_v,
	input  logic      cfg_chr_ram,
	input  logic      mmc3b_mode,
	input  logic      ss_act,
	input  logic      ss_we,
	input  ss_addr_t  ss_addr,
	output rom_addr_t prg_addr,
	output rom_addr_t chr_addr,
	output logic      rom_ce,
	output logic      prg_oe,
	output logic      chr_oe,
	output logic      chr_ce,
	output logic      chr_we,
	output logic      ciram_a10,
	output logic      ciram_ce,
	output logic      map_cpu_oe,
	output logic      irq,
	output byte_t     ss_rdat
);

	byte_t  bank_regs [0:7];
	logic   swap_control;
	logic   chr_invert;
	logic   mirror_mode;
	logic   ram_on;
	block_t block;
	byte_t  reload_val;
	logic   irq_reload_wr;
	logic   irq_disable_wr;
	logic   irq_enable_wr;
	logic   ss_irq_we;
	byte_t  ss_irq_dat;
	byte_t  irq_ctr;
	byte_t  irq_status_byte;

	assign rom_ce = !cpu_ce;
	assign prg_oe = cpu_rw;
	assign chr_oe = !ppu_oe;

	// with prg-ram off the $6000-$7FFF window reads as open bus
	assign map_cpu_oe = cpu_ce & (cpu_addr[14:13] == 2'b11) & !ram_on & cpu_rw;

	mmc3_regs #(
		.MAP_IDX(MAP_IDX)
	) u_regs (
		.m2(m2),
		.map_rst(map_rst),
		.cpu_addr(cpu_addr),
		.cpu_dat(cpu_dat),
		.cpu_ce(cpu_ce),
		.cpu_rw(cpu_rw),
		.cfg_mir_v(cfg_mir_v),
		.ss_act(ss_act),
		.ss_we(ss_we),
		.ss_addr(ss_addr),
		.irq_ctr(irq_ctr),
		.irq_status_byte(irq_status_byte),
		.bank_regs(bank_regs),
		.swap_control(swap_control),
		.chr_invert(chr_invert),
		.mirror_mode(mirror_mode),
		.ram_on(ram_on),
		.block(block),
		.reload_val(reload_val),
		.irq_reload_wr(irq_reload_wr),
		.irq_disable_wr(irq_disable_wr),
		.irq_enable_wr(irq_enable_wr),
		.ss_irq_we(ss_irq_we),
		.ss_irq_dat(ss_irq_dat),
		.ss_rdat(ss_rdat)
	);

	prg_bank_map u_prg (
		.cpu_addr(cpu_addr),
		.cpu_ce(cpu_ce),
		.bank_regs(bank_regs),
		.swap_control(swap_control),
		.block(block),
		.prg_addr(prg_addr)
	);

	chr_bank_map u_chr (
		.ppu_addr(ppu_addr),
		.ppu_we(ppu_we),
		.cfg_chr_ram(cfg_chr_ram),
		.bank_regs(bank_regs),
		.chr_invert(chr_invert),
		.mirror_mode(mirror_mode),
		.block(block),
		.chr_addr(chr_addr),
		.chr_ce(chr_ce),
		.chr_we(chr_we),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce)
	);

	scanline_irq #(
		.A12_QUIET(A12_QUIET)
	) u_irq (
		.m2(m2),
		.map_rst(map_rst),
		.ss_act(ss_act),
		.ppu_addr12(ppu_addr[12]),
		.mmc3b_mode(mmc3b_mode),
		.reload_val(reload_val),
		.irq_reload_wr(irq_reload_wr),
		.irq_disable_wr(irq_disable_wr),
		.irq_enable_wr(irq_enable_wr),
		.ss_irq_we(ss_irq_we),
		.ss_irq_dat(ss_irq_dat),
		.irq(irq),
		.irq_ctr(irq_ctr),
		.irq_status_byte(irq_status_byte)
	);

endmodule

//--- sim/tb_map_205.sv
`timescale 1ns/100ps

module tb_map_205
	import map_205_pkg::*;
();

	localparam int QUIET      = 4;
	localparam int PERIOD     = 40;
	localparam int MAX_CYCLES = 4000; // the sequence below runs for roughly 1500 cycles

	logic      m2;
	logic      map_rst;
	cpu_addr_t cpu_addr;
	byte_t     cpu_dat;
	logic      cpu_ce;
	logic      cpu_rw;
	ppu_addr_t ppu_addr;
	logic      ppu_oe;
	logic      ppu_we;
	logic      cfg_mir_v;
	logic      cfg_chr_ram;
	logic      mmc3b_mode;
	logic      ss_act;
	logic      ss_we;
	ss_addr_t  ss_addr;
	rom_addr_t prg_addr;
	rom_addr_t chr_addr;
	logic      rom_ce;
	logic      prg_oe;
	logic      chr_oe;
	logic      chr_ce;
	logic      chr_we;
	logic      ciram_a10;
	logic      ciram_ce;
	logic      map_cpu_oe;
	logic      irq;
	byte_t     ss_rdat;

	// reference model state
	byte_t  m_regs [0:7];
	byte_t  m_banks [0:7];
	block_t m_block;
	byte_t  m_ctr;
	logic   m_on;
	logic   m_pend;
	logic   m_req;
	int     m_low; // count of consecutive low A12 samples up to QUIET
	logic   check_on;
	string  test_name;

	map_205 #(
		.MAP_IDX(8'd205),
		.A12_QUIET(QUIET)
	) dut (.*);

	always #(PERIOD / 2) m2 = !m2;

	function automatic rom_addr_t expect_prg();
		int bank;
		int base;
		if (cpu_ce)
			bank = 0;
		else
		begin
			case (cpu_addr[14:13])
				2'd0: bank = m_regs[0][6] ? 30 : m_banks[6];
				2'd1: bank = m_banks[7];
				2'd2: bank = m_regs[0][6] ? m_banks[6] : 30;
				default: bank = 31;
			endcase
		end
		// blocks 0 and 1 map 256 KB each and blocks 2 and 3 map 128 KB each
		if (m_block < 2)
			base = m_block * 'h40000 + (bank % 32) * 'h2000;
		else
			base = m_block * 'h20000 + (bank % 16) * 'h2000;
		return rom_addr_t'(base + cpu_addr[12:0]);
	endfunction

	function automatic rom_addr_t expect_chr();
		int slot;
		int bank;
		slot = ppu_addr[12:10];
		if (m_regs[0][7])
			slot = slot ^ 4;
		if (slot < 4)
			bank = (m_banks[slot / 2] & 'hfe) + slot % 2; // 2 KB banks from R0 and R1
		else
			bank = m_banks[slot - 2];
		if (m_block == 0)
			return rom_addr_t'(bank * 'h400 + ppu_addr[9:0]);
		return rom_addr_t'(m_block * 'h20000 + (bank % 128) * 'h400 + ppu_addr[9:0]);
	endfunction

	function automatic byte_t expect_ss();
		if (ss_addr < 8)
			return m_regs[ss_addr];
		if (ss_addr < 16)
			return m_banks[ss_addr - 8];
		if (ss_addr == 16)
			return m_ctr;
		if (ss_addr == 17)
			return {1'b0, m_block, m_on, m_pend, 1'b0, m_req, 1'b0};
		if (ss_addr == 127)
			return 8'd205;
		return 8'hff;
	endfunction

	// true when the A12 level of this cycle clocks the counter down to an irq
	function automatic logic irq_fires();
		if (!(m_on && !ss_act && ppu_addr[12] && m_low >= QUIET))
			return 1'b0;
		if (m_req || (mmc3b_mode && m_ctr == 0))
			return m_regs[4] == 0;
		return m_ctr == 1;
	endfunction

	task automatic update_model();
		logic [2:0] idx;
		logic       rise;
		logic       fire;
		idx  = {cpu_addr[14], cpu_addr[13], cpu_addr[0]};
		rise = ppu_addr[12] && m_low >= QUIET;
		fire = irq_fires();
		if (!ss_act)
		begin
			if (ppu_addr[12])
				m_low = 0;
			else if (m_low < QUIET)
				m_low++;
		end
		if (map_rst)
		begin
			foreach (m_regs[i])
				m_regs[i] = 8'd0;
			m_regs[2] = {7'd0, cfg_mir_v};
			m_banks   = '{8'd0, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd0, 8'd1};
			m_block   = 2'd0;
			m_ctr     = 8'd0;
			m_on      = 1'b0;
			m_pend    = 1'b0;
			m_req     = 1'b0;
		end
		else if (ss_act)
		begin
			if (ss_we && ss_addr < 8)
				m_regs[ss_addr] = cpu_dat;
			else if (ss_we && ss_addr < 16)
				m_banks[ss_addr - 8] = cpu_dat;
			else if (ss_we && ss_addr == 17)
			begin
				m_block = cpu_dat[6:5];
				m_on    = cpu_dat[4];
				m_pend  = cpu_dat[3] ^ cpu_dat[2];
				m_req   = cpu_dat[1] ^ cpu_dat[0];
			end
		end
		else
		begin
			if (rise)
			begin
				if (m_req || m_ctr == 0)
					m_ctr = m_regs[4];
				else
					m_ctr = m_ctr - 8'd1;
				m_req = 1'b0;
				if (fire)
					m_pend = 1'b1;
			end
			if (!cpu_rw && !cpu_ce)
			begin
				if (idx == 3'd1)
					m_banks[m_regs[0][2:0]] = cpu_dat;
				m_regs[idx] = cpu_dat;
				if (idx == 3'd5)
					m_req = 1'b1;
				if (idx == 3'd6)
				begin
					m_on   = 1'b0;
					m_pend = 1'b0;
				end
				if (idx == 3'd7)
					m_on = 1'b1;
			end
			else if (!cpu_rw && cpu_addr[14:13] == 2'b11)
				m_block = cpu_dat[1:0]; // outer block register at $6000-$7FFF
		end
	endtask

	always @(negedge m2)
		update_model();

	task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s %s expected %0h actual %0h", test_name, sig, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", sig);
		end
	endtask

	// outputs are settled well before the falling edge that moves the state
	always @(posedge m2)
	begin
		#12;
		if (check_on)
		begin
			check_value("prg_addr", expect_prg(), prg_addr);
			check_value("chr_addr", expect_chr(), chr_addr);
			check_value("rom_ce", !cpu_ce, rom_ce);
			check_value("prg_oe", cpu_rw, prg_oe);
			check_value("chr_oe", !ppu_oe, chr_oe);
			check_value("chr_ce", !ppu_addr[13], chr_ce);
			check_value("ciram_ce", !ppu_addr[13], ciram_ce);
			check_value("ciram_a10", m_regs[2][0] ? ppu_addr[11] : ppu_addr[10], ciram_a10);
			check_value("chr_we", cfg_chr_ram && !ppu_we && !ppu_addr[13], chr_we);
			check_value("map_cpu_oe",
				cpu_ce && cpu_rw && cpu_addr[14:13] == 2'b11 && !m_regs[3][7], map_cpu_oe);
			check_value("irq", m_pend || irq_fires(), irq);
			check_value("ss_rdat", expect_ss(), ss_rdat);
		end
	end

	function automatic ppu_addr_t random_ppu_addr(input logic a12);
		ppu_addr_t a;
		a     = ppu_addr_t'($urandom);
		a[12] = a12;
		return a;
	endfunction

	task automatic bus_cycle(input logic ce, input logic rw, input cpu_addr_t a, input byte_t d,
			input ppu_addr_t pa);
		@(posedge m2);
		#2;
		cpu_ce   = ce;
		cpu_rw   = rw;
		cpu_addr = a;
		cpu_dat  = d;
		ppu_addr = pa;
		ppu_we   = ($urandom % 4) != 0; // ppu_we is active low and goes low about every fourth cycle
		ppu_oe   = 1'($urandom);
	endtask

	task automatic random_cycle();
		bus_cycle(1'($urandom), 1'b1, cpu_addr_t'($urandom), byte_t'($urandom),
			ppu_addr_t'($urandom));
		ss_addr = ss_addr_t'($urandom);
	endtask

	task automatic reg_write(input logic [2:0] idx, input byte_t d);
		cpu_addr_t a;
		a       = cpu_addr_t'($urandom);
		a[14:13] = idx[2:1];
		a[0]    = idx[0];
		bus_cycle(1'b0, 1'b0, a, d, random_ppu_addr(1'b0));
	endtask

	task automatic block_write(input block_t b);
		cpu_addr_t a;
		byte_t     d;
		a        = cpu_addr_t'($urandom);
		a[14:13] = 2'b11;
		d        = byte_t'($urandom);
		d[1:0]   = b;
		bus_cycle(1'b1, 1'b0, a, d, random_ppu_addr(1'b0));
	endtask

	// A12 stays low for some cycles and then goes high for one
	task automatic a12_line(input int low_cycles);
		repeat (low_cycles)
			bus_cycle(1'b1, 1'b1, cpu_addr_t'($urandom), 8'd0, random_ppu_addr(1'b0));
		bus_cycle(1'b1, 1'b1, cpu_addr_t'($urandom), 8'd0, random_ppu_addr(1'b1));
	endtask

	// the cpu bus keeps running random cycles, writes included, that ss_act holds off
	task automatic ss_access(input logic we, input ss_addr_t a, input byte_t d);
		bus_cycle(1'($urandom), 1'($urandom), cpu_addr_t'($urandom), d, ppu_addr_t'($urandom));
		ss_act  = 1'b1;
		ss_we   = we;
		ss_addr = a;
	endtask

	initial
	begin
		#(MAX_CYCLES * PERIOD);
		$display("timeout, the test sequence did not finish within %0d cycles", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		m2          = 1'b0;
		map_rst     = 1'b1;
		cpu_addr    = '0;
		cpu_dat     = '0;
		cpu_ce      = 1'b1;
		cpu_rw      = 1'b1;
		ppu_addr    = '0;
		ppu_oe      = 1'b1;
		ppu_we      = 1'b1;
		cfg_mir_v   = 1'b0;
		cfg_chr_ram = 1'b0;
		mmc3b_mode  = 1'b0;
		ss_act      = 1'b0;
		ss_we       = 1'b0;
		ss_addr     = '0;
		m_low       = 0;
		check_on    = 1'b0;
		test_name   = "reset_defaults";
		void'($urandom(6870));

		@(negedge m2);
		check_on = 1'b1;
		repeat (10) random_cycle();
		map_rst = 1'b0;
		repeat (30) random_cycle();

		test_name = "bank_writes";
		repeat (50)
		begin
			reg_write(3'd0, byte_t'($urandom)); // also toggles swap and invert
			reg_write(3'd1, byte_t'($urandom));
			repeat (3) random_cycle();
		end

		test_name = "block_select";
		for (int b = 0; b < 4; b++)
		begin
			block_write(block_t'(b));
			repeat (8)
			begin
				reg_write(3'd0, byte_t'($urandom));
				reg_write(3'd1, byte_t'($urandom));
				repeat (2) random_cycle();
			end
		end

		test_name = "mirror_and_enables";
		random_cycle();
		map_rst   = 1'b1;
		cfg_mir_v = 1'b1;
		repeat (2) random_cycle();
		map_rst = 1'b0;
		repeat (60)
		begin
			if ($urandom % 4 == 0)
				reg_write(3'd2, byte_t'($urandom));
			if ($urandom % 4 == 0)
				reg_write(3'd3, byte_t'($urandom));
			random_cycle();
			cfg_chr_ram = 1'($urandom);
		end

		test_name = "scanline_irq";
		for (int mode = 0; mode < 2; mode++)
		begin
			reg_write(3'd6, 8'd0);
			mmc3b_mode = mode[0];
			repeat (3)
			begin
				reg_write(3'd4, byte_t'($urandom % 5)); // zero reload included
				reg_write(3'd5, 8'd0);
				reg_write(3'd7, 8'd0);
				repeat (12) a12_line(QUIET + $urandom % 7);
				repeat (4) a12_line($urandom % QUIET); // too close to count
				reg_write(3'd6, 8'd0);
				a12_line(QUIET + 1);
			end
		end

		test_name = "save_state";
		for (int a = 0; a < 18; a++)
		begin
			if (a != 16)
			begin
				ss_access(1'b1, ss_addr_t'(a), byte_t'($urandom));
				ss_access(1'b0, ss_addr_t'(a), byte_t'($urandom));
			end
		end
		ss_access(1'b0, 8'd16, 8'd0);
		ss_access(1'b0, 8'd127, 8'd0);
		repeat (12) ss_access(1'b0, ss_addr_t'($urandom_range(18, 255)), 8'd0);
		random_cycle();
		ss_act = 1'b0;
		ss_we  = 1'b0;
		repeat (40) random_cycle();

		random_cycle();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- vlog.f
logic/map_205_pkg.sv
logic/mmc3_regs.sv
logic/prg_bank_map.sv
logic/chr_bank_map.sv
logic/scanline_irq.sv
logic/map_205.sv
sim/tb_map_205.sv

//--- Bender.yml
package:
  name: map_205

sources:
  - logic/map_205_pkg.sv
  - logic/mmc3_regs.sv
  - logic/prg_bank_map.sv
  - logic/chr_bank_map.sv
  - logic/scanline_irq.sv
  - logic/map_205.sv
  - target: test
    files:
      - sim/tb_map_205.sv
